// ==== compile.f ====
verilog/fifo_cfg_pkg.sv
verilog/fifo_ptr_pkg.sv
verilog/fifo_ram_if.sv
verilog/fifo_dpram.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo.sv
verif/async_fifo_assert.sv
verif/async_fifo_tb.sv

// ==== verif/async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb;

  localparam int WR_PERIOD     = 4;
  localparam int RD_PERIOD     = 6;
  localparam int DEPTH         = 16;
  localparam int AFULL         = 15;
  localparam int AEMPTY        = 1;
  localparam int FILL_LIMIT    = 32;
  localparam int EXTRA_PULSES  = 8;
  localparam int DRAIN_LIMIT   = 48;
  localparam int RAND_PHASES   = 4;
  localparam int PHASE_CYCLES  = 500;  // 2000 write cycles over all phases.
  localparam int THRESH_ROUNDS = 8;
  localparam int ROUND_CYCLES  = 40;
  localparam int TOTAL_CYCLES  = 10 + FILL_LIMIT + EXTRA_PULSES + 5 + DRAIN_LIMIT +
                                 2 * EXTRA_PULSES + RAND_PHASES * PHASE_CYCLES +
                                 THRESH_ROUNDS * ROUND_CYCLES;

  logic       wr_clk = 1'b0;
  logic       rd_clk = 1'b0;
  logic       wr_rst_n = 1'b0;
  logic       rd_rst_n = 1'b0;
  logic       wr_en = 1'b0;
  logic       rd_en = 1'b0;
  logic [7:0] wr_data = 8'h00;
  logic [7:0] rd_data;
  logic       full, empty, afull, aempty;

  integer     seed = 32'hdd6e_54da;
  logic [7:0] model_q [$];
  logic [7:0] rd_expect;
  logic       rd_pending = 1'b0;
  bit         writer_done;
  int         wr_accepts, rd_pops, checks, errors;
  int         wr_prob, rd_prob;

  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;

  async_fifo dut0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  bind async_fifo async_fifo_assert #(.FIFO_DEPTH(FIFO_DEPTH)) u_assert (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .full        (full),
    .empty       (empty),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error: %s expected 0x%0h, actual 0x%0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("check failed at %0t: %s", $time, what);
    end
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    end
  endtask

  function automatic int rand_percent();
    return $unsigned($random(seed)) % 100;
  endfunction

  task automatic write_cycle(input bit en);
    @(negedge wr_clk);
    wr_en   = en;
    wr_data = 8'($random(seed));
  endtask

  task automatic read_cycle(input bit en);
    @(negedge rd_clk);
    rd_en = en;
  endtask

  // each flag is sampled at a falling edge of its own clock.
  task automatic compare_levels();
    int count;
    fork
      repeat (6) @(negedge wr_clk);
      repeat (6) @(negedge rd_clk);
    join
    @(negedge wr_clk);
    count = model_q.size();
    check_value("full", count == DEPTH, full);
    check_value("afull", count >= AFULL, afull);
    @(negedge rd_clk);
    check_value("empty", count == 0, empty);
    check_value("aempty", count <= AEMPTY, aempty);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_accepts++;
    end
  end

  always @(posedge rd_clk) begin
    if (rd_pending) begin
      check_value("rd_data", rd_expect, rd_data);  // word from the previous pop.
      rd_pending = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      expect_true(model_q.size() > 0, "read accepted while the model held no data");
      if (model_q.size() > 0) begin
        rd_expect  = model_q.pop_front();
        rd_pending = 1'b1;
        rd_pops++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int         errs;
    int         base;
    int         n;
    logic [7:0] held;
    fork
      begin
        repeat (10) @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (10) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join

    errs = errors;
    @(negedge wr_clk);
    check_value("full", 0, full);
    check_value("afull", 0, afull);
    @(negedge rd_clk);
    check_value("empty", 1, empty);
    check_value("aempty", 1, aempty);
    end_test(1, "reset flags", errs);

    errs = errors;
    base = wr_accepts;
    n = 0;
    while (!full && n < FILL_LIMIT) begin
      write_cycle(1'b1);
      n++;
    end
    expect_true(full, "full never rose while filling");
    repeat (EXTRA_PULSES) write_cycle(1'b1);  // must all be dropped.
    write_cycle(1'b0);
    check_value("accepted writes", DEPTH, wr_accepts - base);
    repeat (5) @(negedge wr_clk);
    check_value("full", 1, full);
    check_value("afull", 1, afull);
    end_test(2, "fill", errs);

    errs = errors;
    base = rd_pops;
    n = 0;
    while (rd_pops - base < DEPTH && n < DRAIN_LIMIT) begin
      read_cycle(1'b1);
      n++;
    end
    read_cycle(1'b0);
    check_value("words read", DEPTH, rd_pops - base);
    check_value("model count", 0, model_q.size());
    check_value("empty", 1, empty);
    held = rd_data;
    repeat (EXTRA_PULSES) read_cycle(1'b1);
    read_cycle(1'b0);
    check_value("words read", DEPTH, rd_pops - base);
    check_value("empty", 1, empty);
    check_value("rd_data", held, rd_data);
    end_test(3, "drain", errs);

    errs = errors;
    base = rd_pops;
    writer_done = 1'b0;
    wr_prob = 20 + rand_percent() % 70;
    rd_prob = 20 + rand_percent() % 70;
    fork
      begin
        for (int p = 0; p < RAND_PHASES; p++) begin
          repeat (PHASE_CYCLES) write_cycle(rand_percent() < wr_prob);
          wr_prob = 20 + rand_percent() % 70;  // next phase.
          rd_prob = 20 + rand_percent() % 70;
        end
        write_cycle(1'b0);
        writer_done = 1'b1;
      end
      begin
        while (!writer_done) read_cycle(rand_percent() < rd_prob);
        read_cycle(1'b0);
      end
    join
    expect_true(rd_pops > base, "no word was read during random traffic");
    end_test(4, "random traffic", errs);

    errs = errors;
    for (int r = 0; r < THRESH_ROUNDS; r++) begin
      n = rand_percent() % (DEPTH + 1);
      repeat (n) write_cycle(1'b1);
      write_cycle(1'b0);
      n = rand_percent() % 13;
      repeat (n) read_cycle(1'b1);
      read_cycle(1'b0);
      compare_levels();
    end
    end_test(5, "thresholds", errs);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // twice the whole stimulus length at the slower clock.
  initial begin
    #(TOTAL_CYCLES * RD_PERIOD * 2);
    $display("watchdog expired: the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verif/async_fifo_assert.sv ====
`timescale 1ns/1ps

module async_fifo_assert #(
  parameter int FIFO_DEPTH = fifo_cfg_pkg::DEF_FIFO_DEPTH
) (
  input logic                                         wr_clk,
  input logic                                         wr_rst_n,
  input logic                                         rd_clk,
  input logic                                         rd_rst_n,
  input logic                                         full,
  input logic                                         empty,
  input logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] wr_ptr_gray,
  input logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] rd_ptr_gray
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flag and pointer rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  no_full_and_empty: assert property (@(posedge wr_clk) disable iff (!wr_rst_n || !rd_rst_n)
    !(full && empty)) else $error("full and empty high together");

  wr_ptr_held: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |=> $stable(wr_ptr_gray)) else $error("write pointer moved while full");

  rd_ptr_held: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |=> $stable(rd_ptr_gray)) else $error("read pointer moved while empty");

  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
    else $error("write gray pointer changed more than one bit");

endmodule

// ==== verilog/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = fifo_cfg_pkg::DEF_FIFO_AFULL,
  parameter int FIFO_AEMPTY = fifo_cfg_pkg::DEF_FIFO_AEMPTY
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // gray pointers crossing between the domains.
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr_gray;

  fifo_ram_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_if ();

  assign ram_if.wr_data = wr_data;
  assign rd_data        = ram_if.rd_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull),
    .ram         (ram_if.wr_ctrl)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fifo_rd_ctrl #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty),
    .ram         (ram_if.rd_ctrl)
  );

  fifo_dpram #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dpram (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .ram    (ram_if.mem)
  );

endmodule

// ==== verilog/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module fifo_rd_ctrl #(
  parameter int FIFO_DEPTH  = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AEMPTY = fifo_cfg_pkg::DEF_FIFO_AEMPTY
) (
  input  logic                                         rd_clk,
  input  logic                                         rd_rst_n,
  input  logic                                         rd_en,
  input  logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] wr_ptr_gray,
  output logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] rd_ptr_gray,
  output logic                                         empty,
  output logic                                         aempty,
  fifo_ram_if.rd_ctrl                                  ram
);

  import fifo_ptr_pkg::*;

  localparam int PTR_WIDTH  = ptr_width(FIFO_DEPTH);
  localparam int ADDR_WIDTH = PTR_WIDTH - 1;

  logic                 rd_vld;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr_nxt;
  logic [PTR_WIDTH-1:0] wr_gray_s1;
  logic [PTR_WIDTH-1:0] wr_gray_s2;
  logic [PTR_WIDTH-1:0] wr_ptr_bin;
  logic [PTR_WIDTH-1:0] rd_level_nxt;

  assign rd_vld     = rd_en & ~empty;  // no pop from an empty FIFO.
  assign rd_ptr_nxt = rd_ptr + PTR_WIDTH'(rd_vld);

  // RAM read port registers the word at this same edge.
  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= PTR_WIDTH'(bin2gray(ptr_word_t'(rd_ptr_nxt)));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer sync
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_ptr_bin = PTR_WIDTH'(gray2bin(ptr_word_t'(wr_gray_s2)));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // lagging write pointer keeps the level low, so empty errs on the safe side.
  assign rd_level_nxt = wr_ptr_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_ptr_nxt == wr_ptr_bin);
      aempty <= (rd_level_nxt <= PTR_WIDTH'(FIFO_AEMPTY));
    end
  end

endmodule

// ==== verilog/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module fifo_wr_ctrl #(
  parameter int FIFO_DEPTH = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL = fifo_cfg_pkg::DEF_FIFO_AFULL
) (
  input  logic                                         wr_clk,
  input  logic                                         wr_rst_n,
  input  logic                                         wr_en,
  input  logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] rd_ptr_gray,
  output logic [fifo_ptr_pkg::ptr_width(FIFO_DEPTH)-1:0] wr_ptr_gray,
  output logic                                         full,
  output logic                                         afull,
  fifo_ram_if.wr_ctrl                                  ram
);

  import fifo_ptr_pkg::*;

  localparam int PTR_WIDTH  = ptr_width(FIFO_DEPTH);
  localparam int ADDR_WIDTH = PTR_WIDTH - 1;

  logic                 wr_vld;
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr_nxt;
  logic [PTR_WIDTH-1:0] rd_gray_s1;
  logic [PTR_WIDTH-1:0] rd_gray_s2;
  logic [PTR_WIDTH-1:0] rd_ptr_bin;
  logic [PTR_WIDTH-1:0] wr_level_nxt;
  logic                 full_nxt;

  assign wr_vld     = wr_en & ~full;  // writes into a full FIFO are dropped.
  assign wr_ptr_nxt = wr_ptr + PTR_WIDTH'(wr_vld);

  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr[ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= PTR_WIDTH'(bin2gray(ptr_word_t'(wr_ptr_nxt)));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer sync
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_ptr_bin = PTR_WIDTH'(gray2bin(ptr_word_t'(rd_gray_s2)));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_level_nxt = wr_ptr_nxt - rd_ptr_bin;  // stale read side, so never too low.
  assign full_nxt     = (wr_ptr_nxt[ADDR_WIDTH] != rd_ptr_bin[ADDR_WIDTH]) &&
                        (wr_ptr_nxt[ADDR_WIDTH-1:0] == rd_ptr_bin[ADDR_WIDTH-1:0]);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= (wr_level_nxt >= PTR_WIDTH'(FIFO_AFULL));
    end
  end

endmodule

// ==== verilog/fifo_dpram.sv ====
`timescale 1ns/1ps

module fifo_dpram #(
  parameter int DATA_WIDTH = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH = fifo_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic      wr_clk,
  input  logic      rd_clk,
  fifo_ram_if.mem   ram
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // word stays put until the next accepted read.
  always_ff @(posedge rd_clk) begin
    if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

// ==== verilog/fifo_ram_if.sv ====
`timescale 1ns/1ps

interface fifo_ram_if #(
  parameter int DATA_WIDTH = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = $clog2(fifo_cfg_pkg::DEF_FIFO_DEPTH)
);

  // write port, wr_clk domain.
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  // read port, rd_clk domain.
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;

  modport wr_ctrl (
    output wr_en,
    output wr_addr
  );

  modport rd_ctrl (
    output rd_en,
    output rd_addr
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// ==== verilog/fifo_ptr_pkg.sv ====
package fifo_ptr_pkg;

  // widest pointer the helpers handle.
  localparam int PTR_MAX_WIDTH = 32;

  typedef logic [PTR_MAX_WIDTH-1:0] ptr_word_t;

  // address bits plus the wrap bit.
  function automatic int ptr_width(input int depth);
    return $clog2(depth) + 1;
  endfunction

  function automatic ptr_word_t bin2gray(input ptr_word_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_word_t gray2bin(input ptr_word_t gray);
    ptr_word_t bin;
    bin[PTR_MAX_WIDTH-1] = gray[PTR_MAX_WIDTH-1];
    for (int i = PTR_MAX_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // running xor from the top.
    end
    return bin;
  endfunction

endpackage

// ==== verilog/fifo_cfg_pkg.sv ====
package fifo_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // default FIFO configuration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DEF_DATA_WIDTH  = 8;   // bits per word.
  localparam int DEF_FIFO_DEPTH  = 16;  // power of two.
  localparam int DEF_FIFO_AFULL  = 15;  // one below depth.
  localparam int DEF_FIFO_AEMPTY = 1;

endpackage
